// ==== load_pkg.sv ====
/*
 * Download bus package
 * Widths and types of the host download stream and of the ROM write path,
 * the index code that marks a cheat download, and the cartridge header
 * byte addresses watched while a cartridge streams in.
 */
`default_nettype none

package load_pkg;

	////////////////////////////////
	// Bus and storage widths
	////////////////////////////////
	localparam int ADDR_W     = 25;
	localparam int WORD_W     = 16;
	localparam int ROM_ADDR_W = ADDR_W - 1;   // Word address, no byte bit
	localparam int INDEX_W    = 8;
	localparam int GG_CODE_W  = 128;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
	typedef logic [INDEX_W-1:0]    index_t;

	// Flags, address, compare, replace from top to bottom
	typedef logic [GG_CODE_W-1:0]  gg_code_t;

	// All ones marks a cheat block, anything else is a cartridge
	localparam index_t CODE_INDEX = '1;

	////////////////////////////////
	// Cartridge header offsets
	////////////////////////////////
	localparam addr_t ID_FIRST_ADDR    = 25'h182;  // Product ID starts at high byte
	localparam addr_t ID_CHECK_ADDR    = 25'h18C;  // ID complete, run the lookup
	localparam addr_t HDR_REGION_ADDR  = 25'h1F0;
	localparam addr_t HDR_REGION2_ADDR = 25'h1F2;
	localparam addr_t HDR_END_ADDR     = 25'h200;  // Header fully received

endpackage

`default_nettype wire

// ==== cart_pkg.sv ====
/*
 * Cartridge identity package
 * Console region and priority encodings, compatibility flags, lightgun
 * settings and the product ID table used for the quirk lookup.
 */
`default_nettype none

package cart_pkg;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	// Search order used when the header names more than one region
	typedef enum logic [1:0] {
		US_EU_JP = 2'd0,
		EU_US_JP = 2'd1,
		US_JP_EU = 2'd2,
		JP_US_EU = 2'd3
	} region_prio_e;

	typedef logic [3:0]  quirk_t;
	typedef logic [7:0]  sensor_delay_t;
	typedef logic [63:0] cart_id_t;           // Eight ASCII chars, first char on top

	// Bit positions inside quirk_t
	localparam int QUIRK_SRAM   = 3;
	localparam int QUIRK_EEPROM = 2;
	localparam int QUIRK_NORAM  = 1;
	localparam int QUIRK_SVP    = 0;

	////////////////////////////////
	// Lightgun timing
	////////////////////////////////
	localparam sensor_delay_t DEFAULT_SENSOR_DELAY = 8'd44;
	localparam sensor_delay_t BODY_SENSOR_DELAY    = 8'd100;
	localparam sensor_delay_t LETHAL_SENSOR_DELAY  = 8'd52;

	////////////////////////////////
	// Product ID table
	////////////////////////////////
	localparam cart_id_t ID_SRAM_A     = "T-081276";
	localparam cart_id_t ID_SRAM_B     = "T-81406 ";
	localparam cart_id_t ID_EEPROM_A   = "MK-1215 ";
	localparam cart_id_t ID_EEPROM_B   = "G-4060  ";
	localparam cart_id_t ID_NORAM      = "T-113016";  // Fake RAM check
	localparam cart_id_t ID_SVP        = "MK-1229 ";  // DSP cartridge
	localparam cart_id_t ID_GUN_BODY   = "MK-1533 ";  // Menacer title
	localparam cart_id_t ID_GUN_LETHAL = "T-95096-";  // Justifier title

endpackage

`default_nettype wire

// ==== load_bus_if.sv ====
/*
 * Download bus
 * One host stream of 16-bit words, seen by every loader peer.
 * The host side drives it, the peers only listen.
 */
`timescale 1ns/100ps
`default_nettype none

interface load_bus_if (
	input logic clk_sys,
	input logic RESET
);
	import load_pkg::*;

	logic   active;   // High for the whole download
	logic   wr;       // One-cycle write strobe
	addr_t  addr;     // Byte address of the word
	word_t  data;
	index_t index;    // Selects cartridge or cheat block

	modport host  (input clk_sys, RESET, output active, wr, addr, data, index);
	modport snoop (input clk_sys, RESET, active, wr, addr, data, index);

endinterface

`default_nettype wire

// ==== rom_writer.sv ====
/*
 * ROM writer
 * Passes each cartridge word on to ROM storage with a toggle handshake
 * and holds the host off with a wait level until storage has taken it.
 * Keeps the final download address as the ROM size.
 */
`timescale 1ns/100ps
`default_nettype none

module rom_writer (
	load_bus_if.snoop            bus,
	input  logic                 rom_wr_ack,
	output logic                 rom_wr_req,
	output load_pkg::rom_addr_t  rom_wr_addr,
	output load_pkg::word_t      rom_wr_data,
	output logic                 dl_wait,
	output load_pkg::addr_t      rom_size
);
	import load_pkg::*;

	logic cart_dl;
	logic cart_dl_q;   // Last cycle's cart_dl, for the end edge
	logic cart_wr;

	assign cart_dl = bus.active && (bus.index != CODE_INDEX);
	assign cart_wr = cart_dl && bus.wr;

	always_ff @(posedge bus.clk_sys) begin
		if (bus.RESET) begin
			cart_dl_q  <= 1'b0;
			rom_wr_req <= 1'b0;
			dl_wait    <= 1'b0;
			rom_size   <= '0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl_q && !cart_dl)
				rom_size <= bus.addr;             // Last address seen

			if (cart_wr) begin
				rom_wr_req <= ~rom_wr_req;
				dl_wait    <= 1'b1;
			end else if (dl_wait && (rom_wr_ack == rom_wr_req)) begin
				dl_wait <= 1'b0;                  // Storage caught up
			end
		end
	end

	// Storage expects the first byte in the upper half
	always_ff @(posedge bus.clk_sys) begin
		if (cart_wr) begin
			rom_wr_addr <= bus.addr[ADDR_W-1:1];
			rom_wr_data <= {bus.data[7:0], bus.data[15:8]};
		end
	end

endmodule

`default_nettype wire

// ==== header_region.sv ====
/*
 * Header region decoder
 * Watches the region characters of the cartridge header while it loads
 * and, once the header is complete, requests a console region either by
 * priority order or straight from the download index.
 */
`timescale 1ns/100ps
`default_nettype none

module header_region (
	load_bus_if.snoop              bus,
	input  logic                   region_auto,
	input  logic                   region_from_index,
	input  cart_pkg::region_prio_e region_prio,
	output cart_pkg::region_e      region_req,
	output logic                   region_set
);
	import load_pkg::*;
	import cart_pkg::*;

	logic       cart_dl, cart_dl_q, cart_wr;
	logic [2:0] hdr, hdr_nxt;       // Present flags, indexed by region_e
	logic       hdr_ready, ready_q;
	logic [7:0] lo_byte, hi_byte;
	logic [3:0] hex_val;
	logic       is_letter, is_hex;

	assign cart_dl = bus.active && (bus.index != CODE_INDEX);
	assign cart_wr = cart_dl && bus.wr;
	assign lo_byte = bus.data[7:0];
	assign hi_byte = bus.data[15:8];

	assign is_letter = (lo_byte == "J") || (lo_byte == "U") || (lo_byte == "E");
	assign is_hex    = ((lo_byte >= "0") && (lo_byte <= "9")) ||
	                   ((lo_byte >= "A") && (lo_byte <= "F"));
	assign hex_val   = (lo_byte >= "A") ? lo_byte[3:0] - 4'd7 : lo_byte[3:0];

	function automatic logic [2:0] mark_letter(input logic [2:0] f, input logic [7:0] c);
		logic [2:0] r;
		r = f;
		if (c == "J")      r[REGION_JP] = 1'b1;
		else if (c == "U") r[REGION_US] = 1'b1;
		else if (c == "E") r[REGION_EU] = 1'b1;
		return r;
	endfunction

	// First present region in the chosen order, else the order's head
	function automatic region_e pick_region(input region_prio_e prio, input logic [2:0] f);
		region_e order [3];
		case (prio)
			US_EU_JP: order = '{REGION_US, REGION_EU, REGION_JP};
			EU_US_JP: order = '{REGION_EU, REGION_US, REGION_JP};
			US_JP_EU: order = '{REGION_US, REGION_JP, REGION_EU};
			default:  order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		pick_region = order[0];
		for (int i = 2; i >= 0; i--)
			if (f[order[i]]) pick_region = order[i];
	endfunction

	always_comb begin
		hdr_nxt = hdr;
		if (!cart_dl_q && cart_dl)
			hdr_nxt = '0;                            // New cartridge
		if (cart_wr && (bus.addr == HDR_REGION_ADDR)) begin
			if (is_letter)
				hdr_nxt = mark_letter(hdr_nxt, lo_byte);
			else if (is_hex)
				hdr_nxt = {hex_val[3], hex_val[2], hex_val[0]};  // E, U, J bits
			hdr_nxt = mark_letter(hdr_nxt, hi_byte);
		end
		if (cart_wr && (bus.addr == HDR_REGION2_ADDR))
			hdr_nxt = mark_letter(hdr_nxt, lo_byte);
	end

	always_ff @(posedge bus.clk_sys) begin
		if (bus.RESET) begin
			cart_dl_q  <= 1'b0;
			hdr        <= '0;
			hdr_ready  <= 1'b0;
			ready_q    <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			hdr       <= hdr_nxt;
			ready_q   <= hdr_ready;

			if (cart_dl_q && !cart_dl)
				hdr_ready <= 1'b0;
			else if (cart_wr && (bus.addr == HDR_END_ADDR))
				hdr_ready <= 1'b1;

			////////////////////////////////
			// Region decision
			if (region_auto && !ready_q && hdr_ready) begin
				if (region_from_index) begin
					region_set <= |bus.index;
					region_req <= region_e'(bus.index[7:6]);
				end else begin
					region_set <= 1'b1;
					region_req <= pick_region(region_prio, hdr);
				end
			end
			if (ready_q && !hdr_ready)
				region_set <= 1'b0;                   // Download over
		end
	end

endmodule

`default_nettype wire

// ==== cart_quirks.sv ====
/*
 * Cartridge quirk lookup
 * Collects the product ID from the header and matches it against a small
 * table to raise compatibility flags and pick lightgun type and delay.
 */
`timescale 1ns/100ps
`default_nettype none

module cart_quirks (
	load_bus_if.snoop              bus,
	output cart_pkg::quirk_t       quirks,
	output logic                   gun_type,
	output cart_pkg::sensor_delay_t gun_sensor_delay
);
	import load_pkg::*;
	import cart_pkg::*;

	logic          cart_dl, cart_dl_q, cart_wr;
	cart_id_t      cart_id;
	word_t         swapped;
	quirk_t        id_quirks;
	logic          id_gun_type;
	sensor_delay_t id_delay;

	assign cart_dl = bus.active && (bus.index != CODE_INDEX);
	assign cart_wr = cart_dl && bus.wr;
	assign swapped = {bus.data[7:0], bus.data[15:8]};

	// ID bytes, first character in the top byte
	always_ff @(posedge bus.clk_sys) begin
		if (cart_wr) begin
			case (bus.addr)
				ID_FIRST_ADDR:         cart_id[63:56] <= bus.data[15:8];
				ID_FIRST_ADDR + 25'd2: cart_id[55:40] <= swapped;
				ID_FIRST_ADDR + 25'd4: cart_id[39:24] <= swapped;
				ID_FIRST_ADDR + 25'd6: cart_id[23:8]  <= swapped;
				ID_FIRST_ADDR + 25'd8: cart_id[7:0]   <= bus.data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////
	// Table lookup
	always_comb begin
		id_quirks   = '0;
		id_gun_type = 1'b0;
		id_delay    = DEFAULT_SENSOR_DELAY;
		case (cart_id)
			ID_SRAM_A, ID_SRAM_B:     id_quirks[QUIRK_SRAM]   = 1'b1;
			ID_EEPROM_A, ID_EEPROM_B: id_quirks[QUIRK_EEPROM] = 1'b1;
			ID_NORAM:                 id_quirks[QUIRK_NORAM]  = 1'b1;
			ID_SVP:                   id_quirks[QUIRK_SVP]    = 1'b1;
			ID_GUN_BODY:              id_delay = BODY_SENSOR_DELAY;
			ID_GUN_LETHAL: begin
				id_gun_type = 1'b1;                  // Two-gun adapter
				id_delay    = LETHAL_SENSOR_DELAY;
			end
			default: ;
		endcase
	end

	always_ff @(posedge bus.clk_sys) begin
		if (bus.RESET) begin
			cart_dl_q        <= 1'b0;
			quirks           <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= DEFAULT_SENSOR_DELAY;
		end else begin
			cart_dl_q <= cart_dl;
			if (!cart_dl_q && cart_dl)
				quirks <= '0;                         // Fresh cartridge
			if (cart_wr && (bus.addr == ID_CHECK_ADDR)) begin
				quirks           <= id_quirks;
				gun_type         <= id_gun_type;
				gun_sensor_delay <= id_delay;
			end
		end
	end

endmodule

`default_nettype wire

// ==== cheat_loader.sv ====
/*
 * Cheat code loader
 * Builds 128-bit cheat codes from groups of eight words streamed on a
 * cheat download and strobes each finished code.
 */
`timescale 1ns/100ps
`default_nettype none

module cheat_loader (
	load_bus_if.snoop           bus,
	output load_pkg::gg_code_t  gg_code,
	output logic                code_valid,
	output logic                gg_reset
);
	import load_pkg::*;

	logic       code_wr;
	logic [2:0] slot;    // 16-bit slice inside gg_code

	assign code_wr = bus.active && bus.wr && (bus.index == CODE_INDEX);

	// Field order is reversed against the offsets, low word first in each
	assign slot = {~bus.addr[3:2], bus.addr[1]};

	always_ff @(posedge bus.clk_sys) begin
		if (code_wr && !bus.addr[0])
			gg_code[slot * WORD_W +: WORD_W] <= bus.data;
	end

	always_ff @(posedge bus.clk_sys) begin
		if (bus.RESET) begin
			code_valid <= 1'b0;
			gg_reset   <= 1'b0;
		end else begin
			code_valid <= code_wr && (bus.addr[3:0] == 4'd14);  // Replace high word
			gg_reset   <= code_wr && (bus.addr == '0);          // New cheat list
		end
	end

endmodule

`default_nettype wire

// ==== cart_loader.sv ====
/*
 * Cartridge loader top
 * Puts the host download stream on a shared bus and hands it to the ROM
 * writer, region decoder, quirk lookup and cheat loader.
 */
`timescale 1ns/100ps
`default_nettype none

module cart_loader (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  load_pkg::addr_t         dl_addr,
	input  load_pkg::word_t         dl_data,
	input  load_pkg::index_t        dl_index,
	input  logic                    rom_wr_ack,
	input  logic                    region_auto,
	input  logic                    region_from_index,
	input  cart_pkg::region_prio_e  region_prio,
	output logic                    rom_wr_req,
	output load_pkg::rom_addr_t     rom_wr_addr,
	output load_pkg::word_t         rom_wr_data,
	output logic                    dl_wait,
	output load_pkg::addr_t         rom_size,
	output cart_pkg::region_e       region_req,
	output logic                    region_set,
	output cart_pkg::quirk_t        quirks,
	output logic                    gun_type,
	output cart_pkg::sensor_delay_t gun_sensor_delay,
	output load_pkg::gg_code_t      gg_code,
	output logic                    code_valid,
	output logic                    gg_reset
);

	load_bus_if bus (.clk_sys(clk_sys), .RESET(RESET));

	// Host side of the bus
	assign bus.active = dl_active;
	assign bus.wr     = dl_wr;
	assign bus.addr   = dl_addr;
	assign bus.data   = dl_data;
	assign bus.index  = dl_index;

	rom_writer i_rom_writer (.bus(bus), .rom_wr_ack(rom_wr_ack), .rom_wr_req(rom_wr_req),
		.rom_wr_addr(rom_wr_addr), .rom_wr_data(rom_wr_data), .dl_wait(dl_wait),
		.rom_size(rom_size));

	header_region i_header_region (.bus(bus), .region_auto(region_auto),
		.region_from_index(region_from_index), .region_prio(region_prio),
		.region_req(region_req), .region_set(region_set));

	cart_quirks i_cart_quirks (.bus(bus), .quirks(quirks), .gun_type(gun_type),
		.gun_sensor_delay(gun_sensor_delay));

	cheat_loader i_cheat_loader (.bus(bus), .gg_code(gg_code), .code_valid(code_valid),
		.gg_reset(gg_reset));

endmodule

`default_nettype wire

// ==== tb_checks.svh ====
/*
 * Compare tasks for the cartridge loader testbench
 * One task per result type, each stops the run at the first mismatch.
 */

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp)
		abort_run($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
endtask

task automatic check_word(input string name, input load_pkg::word_t exp,
	input load_pkg::word_t act);
	if (act !== exp)
		abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
endtask

task automatic check_addr(input string name, input load_pkg::addr_t exp,
	input load_pkg::addr_t act);
	if (act !== exp)
		abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
endtask

task automatic check_rom_addr(input string name, input load_pkg::rom_addr_t exp,
	input load_pkg::rom_addr_t act);
	if (act !== exp)
		abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
endtask

task automatic check_region(input string name, input cart_pkg::region_e exp,
	input cart_pkg::region_e act);
	if (act !== exp)
		abort_run($sformatf("[ERROR] %s expected %0d actual %0d", name, exp, act));
endtask

task automatic check_quirk(input string name, input cart_pkg::quirk_t exp,
	input cart_pkg::quirk_t act);
	if (act !== exp)
		abort_run($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
endtask

task automatic check_delay(input string name, input cart_pkg::sensor_delay_t exp,
	input cart_pkg::sensor_delay_t act);
	if (act !== exp)
		abort_run($sformatf("[ERROR] %s expected %0d actual %0d", name, exp, act));
endtask

task automatic check_code(input string name, input load_pkg::gg_code_t exp,
	input load_pkg::gg_code_t act);
	if (act !== exp)
		abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
endtask

// ==== tb_cart_loader.sv ====
/*
 * Cartridge loader testbench
 * Streams random cartridge images and cheat blocks into the loader,
 * acknowledges storage writes after a random delay and checks every
 * output against a reference model of the loader rules.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_cart_loader;
	import load_pkg::*;
	import cart_pkg::*;

	localparam int CLK_NS      = 10;
	localparam int N_CARTS     = 10;
	localparam int N_CHEATS    = 4;
	localparam int CHEAT_GRPS  = 4;
	localparam int CART_WORDS  = 257 + 31;   // Longest cartridge stream
	localparam int MAX_WRITES  = N_CARTS * CART_WORDS + N_CHEATS * CHEAT_GRPS * 8;
	localparam int TIMEOUT_CYC = MAX_WRITES * 20 + 1000;

	logic          clk_sys;
	logic          RESET;
	logic          dl_active;
	logic          dl_wr;
	addr_t         dl_addr;
	word_t         dl_data;
	index_t        dl_index;
	logic          rom_wr_ack;
	logic          region_auto;
	logic          region_from_index;
	region_prio_e  region_prio;
	logic          rom_wr_req;
	rom_addr_t     rom_wr_addr;
	word_t         rom_wr_data;
	logic          dl_wait;
	addr_t         rom_size;
	region_e       region_req;
	logic          region_set;
	quirk_t        quirks;
	logic          gun_type;
	sensor_delay_t gun_sensor_delay;
	gg_code_t      gg_code;
	logic          code_valid;
	logic          gg_reset;

	// Model state
	int            seed = 60541;
	logic          exp_req;
	addr_t         exp_size;
	region_e       exp_region;
	logic          exp_set;
	region_e       nxt_region;   // Decision due after the header end
	logic          nxt_set;
	gg_code_t      exp_code;
	cart_id_t      cur_id;
	logic [7:0]    hdr_img [0:511];  // Header bytes by byte address

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped");
	endtask

	`include "tb_checks.svh"

	cart_loader i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(TIMEOUT_CYC * CLK_NS);
		abort_run("Timeout: the loader stopped making progress");
	end

	function automatic int unsigned rnd(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [7:0] letter(input int unsigned n);
		case (n)
			0:       return "J";
			1:       return "U";
			2:       return "E";
			default: return " ";
		endcase
	endfunction

	// Region flag mask {E, U, J} for one header character
	function automatic logic [2:0] mark(input logic [7:0] c);
		if (c == "J") return 3'b001;
		if (c == "U") return 3'b010;
		if (c == "E") return 3'b100;
		return 3'b000;
	endfunction

	function automatic region_e expect_region(input region_prio_e p, input logic [2:0] f);
		logic [5:0] ord;
		region_e    r;
		logic       found;
		int         i;
		case (p)
			US_EU_JP: ord = {REGION_US, REGION_EU, REGION_JP};
			EU_US_JP: ord = {REGION_EU, REGION_US, REGION_JP};
			US_JP_EU: ord = {REGION_US, REGION_JP, REGION_EU};
			default:  ord = {REGION_JP, REGION_US, REGION_EU};
		endcase
		r = region_e'(ord[5:4]);   // Fallback when no flag is present
		found = 1'b0;
		for (i = 0; i < 3; i++) begin
			if (!found && f[ord[5-2*i -: 2]]) begin
				r = region_e'(ord[5-2*i -: 2]);
				found = 1'b1;
			end
		end
		return r;
	endfunction

	task automatic expect_quirks(input cart_id_t id);
		quirk_t        q;
		logic          g;
		sensor_delay_t dly;
		q = 4'b0000;
		g = 1'b0;
		dly = 8'd44;
		if (id == ID_SRAM_A || id == ID_SRAM_B) q = 4'b1000;
		if (id == ID_EEPROM_A || id == ID_EEPROM_B) q = 4'b0100;
		if (id == ID_NORAM) q = 4'b0010;
		if (id == ID_SVP) q = 4'b0001;
		if (id == ID_GUN_BODY) dly = 8'd100;
		if (id == ID_GUN_LETHAL) begin
			g = 1'b1;
			dly = 8'd52;
		end
		check_quirk("quirks lookup", q, quirks);
		check_bit("gun_type lookup", g, gun_type);
		check_delay("gun_sensor_delay lookup", dly, gun_sensor_delay);
	endtask

	////////////////////////////////
	// Bus tasks, entered and left just after a falling edge

	task automatic start_download(input index_t idx);
		dl_active = 1'b1;
		dl_index = idx;
		@(negedge clk_sys);
		if (idx != CODE_INDEX)
			check_quirk("quirks cleared at start", 4'b0000, quirks);
	endtask

	task automatic after_write(input addr_t a, input word_t d, input logic cart);
		int base;
		if (cart) begin
			exp_req = ~exp_req;
			check_rom_addr("rom_wr_addr", rom_addr_t'(a >> 1), rom_wr_addr);
			check_word("rom_wr_data", {d[7:0], d[15:8]}, rom_wr_data);
			if (a == ID_CHECK_ADDR)
				expect_quirks(cur_id);
		end else begin
			// Field 0 is flags on top, second word of a field is its high half
			base = (3 - a[3:2]) * 32 + a[1] * 16;
			exp_code[base +: 16] = d;
		end
		check_bit("rom_wr_req", exp_req, rom_wr_req);
		check_bit("code_valid", !cart && (a[3:0] == 4'd14), code_valid);
		check_bit("gg_reset", !cart && (a == '0), gg_reset);
		if (!cart && a[3:0] == 4'd14)
			check_code("gg_code", exp_code, gg_code);
	endtask

	task automatic write_word(input addr_t a, input word_t d);
		logic cart;
		int   ack_at;   // Falling edge where storage acknowledges
		int   k;
		cart = (dl_index != CODE_INDEX);
		ack_at = cart ? 1 + rnd(6) : 0;
		dl_wr = 1'b1;
		dl_addr = a;
		dl_data = d;
		for (k = 1; k <= ack_at + 1; k++) begin
			@(negedge clk_sys);
			dl_wr = 1'b0;
			if (k == 1)
				after_write(a, d, cart);
			check_bit("dl_wait", cart && (k <= ack_at), dl_wait);
			if (k == ack_at)
				rom_wr_ack = exp_req;
			if (cart && a == HDR_END_ADDR && k == 1)
				check_bit("region_set before decision", exp_set, region_set);
			if (cart && a == HDR_END_ADDR && k == 2) begin
				exp_region = nxt_region;
				exp_set = nxt_set;
				check_region("region_req decision", exp_region, region_req);
				check_bit("region_set decision", exp_set, region_set);
			end
		end
	endtask

	task automatic end_download(input addr_t last);
		if (dl_index != CODE_INDEX)
			exp_size = last;
		dl_active = 1'b0;
		@(negedge clk_sys);
		check_addr("rom_size", exp_size, rom_size);
		check_bit("region_set at end", exp_set, region_set);
		@(negedge clk_sys);
		exp_set = 1'b0;
		check_bit("region_set after end", exp_set, region_set);
		check_region("region_req held", exp_region, region_req);
		check_bit("dl_wait idle", 1'b0, dl_wait);
		check_bit("code_valid idle", 1'b0, code_valid);
		check_bit("gg_reset idle", 1'b0, gg_reset);
	endtask

	////////////////////////////////
	// Download scenarios

	task automatic run_cart();
		index_t     idx;
		int         n;
		int         i;
		int         pick;
		logic [3:0] v;
		logic [2:0] hflags;   // {E, U, J}
		addr_t      a;
		idx = rnd(255);       // Never the cheat index
		n = 257 + rnd(32);
		region_auto = (rnd(4) != 0);
		region_from_index = (rnd(3) == 0);
		region_prio = region_prio_e'(rnd(4));
		for (i = 0; i < 512; i++)
			hdr_img[i] = rnd(256);

		pick = rnd(12);
		case (pick)
			0: cur_id = ID_SRAM_A;
			1: cur_id = ID_SRAM_B;
			2: cur_id = ID_EEPROM_A;
			3: cur_id = ID_EEPROM_B;
			4: cur_id = ID_NORAM;
			5: cur_id = ID_SVP;
			6: cur_id = ID_GUN_BODY;
			7: cur_id = ID_GUN_LETHAL;
			default: for (i = 0; i < 8; i++) cur_id[63-8*i -: 8] = 8'h41 + rnd(26);
		endcase
		for (i = 0; i < 8; i++)
			hdr_img[9'h183 + i] = cur_id[63-8*i -: 8];   // First char at byte 0x183

		if (rnd(4) == 0) begin
			v = rnd(16);
			hdr_img[9'h1F0] = (v < 10) ? 8'h30 + v : 8'h41 + v - 10;
			hflags = mark(hdr_img[9'h1F0]);   // Digit E reads as the letter
			if (hflags == 3'b000)
				hflags = {v[3], v[2], v[0]};
		end else begin
			hdr_img[9'h1F0] = letter(rnd(4));
			hflags = mark(hdr_img[9'h1F0]);
		end
		hdr_img[9'h1F1] = letter(rnd(4));
		hdr_img[9'h1F2] = letter(rnd(4));
		hflags = hflags | mark(hdr_img[9'h1F1]) | mark(hdr_img[9'h1F2]);

		nxt_region = exp_region;
		nxt_set = exp_set;
		if (region_auto && region_from_index) begin
			nxt_region = region_e'(idx[7:6]);
			nxt_set = |idx;
		end else if (region_auto) begin
			nxt_region = expect_region(region_prio, hflags);
			nxt_set = 1'b1;
		end

		start_download(idx);
		for (i = 0; i < n; i++) begin
			a = addr_t'(2 * i);
			if (a < 512)
				write_word(a, {hdr_img[a + 1], hdr_img[a]});   // Low byte at even address
			else
				write_word(a, word_t'(rnd(65536)));
		end
		end_download(addr_t'(2 * (n - 1)));
	endtask

	task automatic run_cheats();
		int g;
		int s;
		start_download(CODE_INDEX);
		for (g = 0; g < CHEAT_GRPS; g++)
			for (s = 0; s < 8; s++)
				write_word(addr_t'(g * 16 + s * 2), word_t'(rnd(65536)));
		end_download(addr_t'(CHEAT_GRPS * 16 - 2));
	endtask

	initial begin
		int t;
		RESET = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		dl_index = '0;
		rom_wr_ack = 1'b0;
		region_auto = 1'b0;
		region_from_index = 1'b0;
		region_prio = US_EU_JP;
		exp_req = 1'b0;
		exp_size = '0;
		exp_region = REGION_JP;
		exp_set = 1'b0;
		exp_code = '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;

		// Reset values
		check_bit("rom_wr_req reset", 1'b0, rom_wr_req);
		check_bit("dl_wait reset", 1'b0, dl_wait);
		check_bit("region_set reset", 1'b0, region_set);
		check_region("region_req reset", REGION_JP, region_req);
		check_bit("code_valid reset", 1'b0, code_valid);
		check_bit("gg_reset reset", 1'b0, gg_reset);
		check_quirk("quirks reset", 4'b0000, quirks);
		check_bit("gun_type reset", 1'b0, gun_type);
		check_delay("gun_sensor_delay reset", 8'd44, gun_sensor_delay);
		check_addr("rom_size reset", '0, rom_size);

		for (t = 0; t < N_CARTS; t++) begin
			run_cart();
			if (t < N_CHEATS)
				run_cheats();
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
load_pkg.sv
cart_pkg.sv
load_bus_if.sv
rom_writer.sv
header_region.sv
cart_quirks.sv
cheat_loader.sv
cart_loader.sv
tb_cart_loader.sv
